//--- bitmap/bitmapStore.sv
`timescale 1ns/1ps

module bitmapStore (
   input  logic                  H2,
   input  logic                  arstN,
   input  videoPkg::bitmapWrT    bitmapWr,
   input  logic [14:0]           bitmapRdAddr,
   output logic [7:0]            bitmapRdData,
   input  videoPkg::videoTimingT timing,
   input  logic [7:0]            hScroll,
   output videoPkg::pixelT       pixel
);
   import videoPkg::*;

   localparam int memBytes = int'(bitmapLast - bitmapBase) + 1;

   logic [7:0]  mem [memBytes];
   logic [7:0]  xScrolled;
   logic [14:0] vidAddr;
   logic [7:0]  vidByte;
   logic        oddPixel;

   // Two pixels per byte, 128 bytes per line
   assign xScrolled = timing.hCount[7:0] + hScroll;
   assign vidAddr   = {timing.vCount, xScrolled[7:1]};

   // CPU port
   always_ff @(posedge H2)
   begin
      if (bitmapWr.wr)
         mem[bitmapWr.addr] <= bitmapWr.data;
      bitmapRdData <= mem[bitmapRdAddr];
   end

   // Video port
   always_ff @(posedge H2)
   begin
      vidByte <= mem[vidAddr];
   end

   pipeDelay #(
      .T     (logic),
      .depth (1)
   ) selDelay (
      .H2    (H2),
      .arstN (arstN),
      .din   (xScrolled[0]),
      .dout  (oddPixel)
   );

   assign pixel = oddPixel ? vidByte[7:4] : vidByte[3:0];   // Odd x in high nibble

endmodule

//--- color/colorMemory.sv
`timescale 1ns/1ps

module colorMemory (
   input  logic                  H2,
   input  logic                  arstN,
   input  videoPkg::paletteWrT   paletteWr,
   input  videoPkg::pixelT       pixel,
   input  videoPkg::videoTimingT timing,
   output logic [8:0]            rgb
);

   logic [8:0] palette [16];

   always_ff @(posedge H2)
   begin
      if (paletteWr.wr)
         palette[paletteWr.index] <= paletteWr.value;
   end

   // Lookup, black outside the visible area
   always_ff @(posedge H2 or negedge arstN)
   begin
      if (!arstN)
         rgb <= '0;
      else if (timing.hBlank || timing.vBlank)
         rgb <= '0;
      else
         rgb <= palette[pixel];
   end

endmodule

//--- common/videoPkg.sv
package videoPkg;

   // Raster timing, counted in pixel clocks and lines
   localparam int hTotal     = 320;
   localparam int hVisible   = 256;
   localparam int hSyncStart = 272;
   localparam int hSyncLen   = 32;

   localparam int vTotal     = 256;
   localparam int vVisible   = 232;
   localparam int vSyncStart = 240;
   localparam int vSyncLen   = 4;

   localparam int irqLineStep = 64;   // Scanline interrupt spacing

   // CPU address map
   localparam logic [15:0] bitmapBase  = 16'h0000;
   localparam logic [15:0] bitmapLast  = 16'h7FFF;
   localparam logic [15:0] paletteBase = 16'h8000;
   localparam int          paletteSize = 32;
   localparam logic [15:0] scrollAddr  = 16'h9000;
   localparam logic [15:0] statusAddr  = 16'h9400;
   localparam logic [15:0] irqAckAddr  = 16'h9800;

   typedef logic [3:0] pixelT;

   typedef struct packed {
      logic [8:0] hCount;
      logic [7:0] vCount;
      logic       hBlank;
      logic       vBlank;
      logic       hSync;
      logic       vSync;
   } videoTimingT;

   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wrData;
      logic        wr;
      logic        rd;
   } cpuBusT;

   typedef struct packed {
      logic [8:0] rgb;   // R 8..6, G 5..3, B 2..0
      logic       hBlank;
      logic       vBlank;
      logic       hSync;
      logic       vSync;
   } videoOutT;

   typedef struct packed {
      logic [14:0] addr;
      logic [7:0]  data;
      logic        wr;
   } bitmapWrT;

   typedef struct packed {
      logic [3:0] index;
      logic [8:0] value;
      logic       wr;
   } paletteWrT;

endpackage

//--- hw/ccVideoTop.sv
`timescale 1ns/1ps

module ccVideoTop (
   input  logic               H2,
   input  logic               arstN,
   input  videoPkg::cpuBusT   bus,
   output logic [7:0]         rdData,
   output logic               irq,
   output videoPkg::videoOutT videoOut
);
   import videoPkg::*;

   videoTimingT timing;
   videoTimingT timingD1;
   videoTimingT timingD2;
   logic        irqReq;
   bitmapWrT    bitmapWr;
   logic [14:0] bitmapRdAddr;
   logic [7:0]  bitmapRdData;
   paletteWrT   paletteWr;
   logic [7:0]  hScroll;
   pixelT       pixel;
   logic [8:0]  rgb;

   videoTiming timingGen (
      .H2     (H2),
      .arstN  (arstN),
      .timing (timing),
      .irqReq (irqReq)
   );

   bitmapStore bitmap (
      .H2           (H2),
      .arstN        (arstN),
      .bitmapWr     (bitmapWr),
      .bitmapRdAddr (bitmapRdAddr),
      .bitmapRdData (bitmapRdData),
      .timing       (timing),
      .hScroll      (hScroll),
      .pixel        (pixel)
   );

   cpuBus busIf (
      .H2           (H2),
      .arstN        (arstN),
      .bus          (bus),
      .rdData       (rdData),
      .irq          (irq),
      .irqReq       (irqReq),
      .vBlank       (timing.vBlank),
      .bitmapWr     (bitmapWr),
      .bitmapRdAddr (bitmapRdAddr),
      .bitmapRdData (bitmapRdData),
      .paletteWr    (paletteWr),
      .hScroll      (hScroll)
   );

   // Blanking for the palette stage, one clock behind the count
   pipeDelay #(.T(videoTimingT), .depth(1)) timingDly1 (
      .H2    (H2),
      .arstN (arstN),
      .din   (timing),
      .dout  (timingD1)
   );

   colorMemory color (
      .H2        (H2),
      .arstN     (arstN),
      .paletteWr (paletteWr),
      .pixel     (pixel),
      .timing    (timingD1),
      .rgb       (rgb)
   );

   pipeDelay #(.T(videoTimingT), .depth(2)) timingDly2 (
      .H2    (H2),
      .arstN (arstN),
      .din   (timing),
      .dout  (timingD2)
   );

   assign videoOut = {rgb, timingD2.hBlank, timingD2.vBlank, timingD2.hSync, timingD2.vSync};

endmodule

//--- hw/cpuBus.sv
`timescale 1ns/1ps

module cpuBus (
   input  logic                H2,
   input  logic                arstN,
   input  videoPkg::cpuBusT    bus,
   output logic [7:0]          rdData,
   output logic                irq,
   input  logic                irqReq,
   input  logic                vBlank,
   output videoPkg::bitmapWrT  bitmapWr,
   output logic [14:0]         bitmapRdAddr,
   input  logic [7:0]          bitmapRdData,
   output videoPkg::paletteWrT paletteWr,
   output logic [7:0]          hScroll
);
   import videoPkg::*;

   logic        inBitmap;
   logic        inPalette;
   logic        isScroll;
   logic        isStatus;
   logic        isAck;
   logic [14:0] rdAddrHold;
   logic        rdFromBitmap;
   logic [7:0]  rdReg;

   assign inBitmap  = bus.addr <= bitmapLast;
   assign inPalette = (bus.addr >= paletteBase) && (bus.addr < paletteBase + paletteSize);
   assign isScroll  = bus.addr == scrollAddr;
   assign isStatus  = bus.addr == statusAddr;
   assign isAck     = bus.addr == irqAckAddr;

   assign bitmapWr.addr = bus.addr[14:0];
   assign bitmapWr.data = bus.wrData;
   assign bitmapWr.wr   = bus.wr && inBitmap;

   // Keep the RAM pointed at the last read so its output stays put
   assign bitmapRdAddr = bus.rd ? bus.addr[14:0] : rdAddrHold;

   // Address bit 4 is the low colour bit
   assign paletteWr.index = bus.addr[3:0];
   assign paletteWr.value = {bus.wrData, bus.addr[4]};
   assign paletteWr.wr    = bus.wr && inPalette;

   always_ff @(posedge H2 or negedge arstN)
   begin
      if (!arstN)
      begin
         hScroll      <= '0;
         irq          <= 1'b0;
         rdFromBitmap <= 1'b0;
         rdReg        <= '0;
      end
      else
      begin
         if (bus.wr && isScroll)
            hScroll <= bus.wrData;

         if (irqReq)
            irq <= 1'b1;   // Request beats a same-cycle ack
         else if (bus.wr && isAck)
            irq <= 1'b0;

         if (bus.rd)
         begin
            rdFromBitmap <= inBitmap;
            rdReg        <= isStatus ? {6'b0, irq, vBlank} : 8'h00;
         end
      end
   end

   always_ff @(posedge H2)
   begin
      if (bus.rd)
         rdAddrHold <= bus.addr[14:0];
   end

   // Bitmap byte arrives from the RAM register, everything else from rdReg
   assign rdData = rdFromBitmap ? bitmapRdData : rdReg;

endmodule

//--- hw/pipeDelay.sv
`timescale 1ns/1ps

module pipeDelay #(
   parameter type T     = logic,
   parameter int  depth = 1
) (
   input  logic H2,
   input  logic arstN,
   input  T     din,
   output T     dout
);

   T stages [depth];

   always_ff @(posedge H2 or negedge arstN)
   begin
      if (!arstN)
      begin
         for (int i = 0; i < depth; i++)
            stages[i] <= '0;
      end
      else
      begin
         stages[0] <= din;
         for (int i = 1; i < depth; i++)
            stages[i] <= stages[i-1];
      end
   end

   assign dout = stages[depth-1];

endmodule

//--- hw/videoTiming.sv
`timescale 1ns/1ps

module videoTiming (
   input  logic                  H2,
   input  logic                  arstN,
   output videoPkg::videoTimingT timing,
   output logic                  irqReq
);
   import videoPkg::*;

   logic [8:0] hCount;
   logic [8:0] hNext;
   logic [7:0] vCount;
   logic [7:0] vNext;
   logic       hBlank;
   logic       vBlank;
   logic       hSync;
   logic       vSync;

   // Next count, line steps on horizontal wrap
   always_comb
   begin
      hNext = hCount + 9'd1;
      vNext = vCount;
      if (hCount == 9'(hTotal - 1))
      begin
         hNext = '0;
         if (vCount == 8'(vTotal - 1))
            vNext = '0;
         else
            vNext = vCount + 8'd1;
      end
   end

   // Flags decoded from the next count so they line up with the counters
   always_ff @(posedge H2 or negedge arstN)
   begin
      if (!arstN)
      begin
         hCount <= '0;
         vCount <= '0;
         hBlank <= 1'b0;
         vBlank <= 1'b0;
         hSync  <= 1'b0;
         vSync  <= 1'b0;
      end
      else
      begin
         hCount <= hNext;
         vCount <= vNext;
         hBlank <= hNext >= 9'(hVisible);
         hSync  <= (hNext >= 9'(hSyncStart)) && (hNext < 9'(hSyncStart + hSyncLen));
         vBlank <= vNext >= 8'(vVisible);
         vSync  <= (vNext >= 8'(vSyncStart)) && (vNext < 8'(vSyncStart + vSyncLen));
      end
   end

   assign timing = {hCount, vCount, hBlank, vBlank, hSync, vSync};

   // First pixel clock of every 64th line
   assign irqReq = (hCount == '0) && ((int'(vCount) % irqLineStep) == 0);

endmodule

//--- project.f
common/videoPkg.sv
hw/pipeDelay.sv
hw/videoTiming.sv
hw/cpuBus.sv
bitmap/bitmapStore.sv
color/colorMemory.sv
hw/ccVideoTop.sv
tests/clockGen.sv
tests/tbCcVideo.sv

//--- runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tbCcVideo -o simv \
   && ./obj_dir/simv | tee sim.log

grep -qx "TB PASSED" sim.log && echo "Simulation result: pass" \
   || { echo "Simulation result: fail"; exit 1; }

//--- tests/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
   parameter real periodNs    = 8.0,
   parameter int  resetCycles = 3
) (
   output logic H2,
   output logic arstN
);

   initial
   begin
      H2 = 1'b0;
      forever #(periodNs / 2.0) H2 = ~H2;
   end

   // Release just after an edge, like the other inputs
   initial
   begin
      arstN = 1'b0;
      repeat (resetCycles) @(posedge H2);
      #1;
      arstN = 1'b1;
   end

endmodule

//--- tests/tbCcVideo.sv
`timescale 1ns/1ps

// Measures period and high time of a level and checks both
module pulseMeter #(
   parameter string name    = "signal",
   parameter int    period  = 2,
   parameter int    highLen = 1
) (
   input  logic H2,
   input  logic arstN,
   input  logic sig,
   output int   checks,
   output int   errors
);
   logic prevSig;
   logic seenRise;
   logic rise;
   logic fall;
   int   sinceRise;
   int   highCnt;
   int   checkCnt = 0;
   int   errCnt = 0;

   assign rise   = sig && !prevSig;
   assign fall   = !sig && prevSig;
   assign checks = checkCnt;
   assign errors = errCnt;

   always @(posedge H2 or negedge arstN)
   begin
      if (!arstN)
      begin
         prevSig   <= 1'b1;   // No edge counted out of reset
         seenRise  <= 1'b0;
         sinceRise <= 0;
         highCnt   <= 0;
      end
      else
      begin
         prevSig   <= sig;
         sinceRise <= rise ? 1 : sinceRise + 1;
         highCnt   <= sig ? highCnt + 1 : 0;
         if (rise)
            seenRise <= 1'b1;
         if (seenRise && (rise || fall))
            checkCnt <= checkCnt + 1;
      end
   end

   assert property (@(posedge H2) disable iff (!arstN) (seenRise && rise) |-> sinceRise == period)
   else
   begin
      errCnt++;
      $display("** Error: %s period = 0x%0h, expected 0x%0h", name, $sampled(sinceRise), period);
   end

   assert property (@(posedge H2) disable iff (!arstN) (seenRise && fall) |-> highCnt == highLen)
   else
   begin
      errCnt++;
      $display("** Error: %s high time = 0x%0h, expected 0x%0h", name, $sampled(highCnt), highLen);
   end

endmodule

module tbCcVideo;
   import videoPkg::*;

   localparam int frameCycles    = hTotal * vTotal;
   localparam int watchdogCycles = 4 * frameCycles + 8192;

   logic       H2;
   logic       arstN;
   cpuBusT     bus;
   logic [7:0] rdData;
   logic       irq;
   videoOutT   vo;

   // Screen position model, taken from the blank edges
   logic [8:0] xReg;
   logic [7:0] lineReg;
   logic       posValid;
   logic       prevHB;
   logic       prevVB;
   logic       prevIrq;
   logic       hFall;
   logic       vFall;
   logic [8:0] curX;
   logic [7:0] curLine;
   logic       curValid;

   // Reference memories and registers
   logic [7:0] bmRef [32768];
   bit         bmKnown [32768];
   logic [8:0] palRef [16];
   logic [7:0] refScroll;
   logic       refIrq;
   logic       irqNow;
   logic       reqSeen;
   logic       ackSeen;
   logic [7:0] aheadLine;
   logic [7:0] rdExpNow;
   logic [7:0] rdExp;
   logic       rdKnown;
   logic       rdPend;
   logic       pixChk;
   logic       pixCond;
   logic [7:0] srcX;
   int         pixAddr;
   logic [7:0] pixByte;
   logic [8:0] pixExp;

   int errCount    = 0;
   int blankErrs   = 0;
   int vbErrs      = 0;
   int pixChecks   = 0;
   int blankChecks = 0;
   int readChecks  = 0;
   int irqRises    = 0;
   int hsChecks;
   int hsErrs;
   int vsChecks;
   int vsErrs;
   int hbChecks;
   int hbErrs;

   clockGen #(.periodNs(8.0), .resetCycles(3)) clocks (
      .H2    (H2),
      .arstN (arstN)
   );

   ccVideoTop DUT (
      .H2       (H2),
      .arstN    (arstN),
      .bus      (bus),
      .rdData   (rdData),
      .irq      (irq),
      .videoOut (vo)
   );

   pulseMeter #(.name("hSync"), .period(hTotal), .highLen(hSyncLen)) hSyncMeter (
      .H2     (H2),
      .arstN  (arstN),
      .sig    (vo.hSync),
      .checks (hsChecks),
      .errors (hsErrs)
   );

   pulseMeter #(.name("vSync"), .period(frameCycles), .highLen(vSyncLen * hTotal)) vSyncMeter (
      .H2     (H2),
      .arstN  (arstN),
      .sig    (vo.vSync),
      .checks (vsChecks),
      .errors (vsErrs)
   );

   pulseMeter #(.name("hBlank low"), .period(hTotal), .highLen(hVisible)) hBlankMeter (
      .H2     (H2),
      .arstN  (arstN),
      .sig    (!vo.hBlank),
      .checks (hbChecks),
      .errors (hbErrs)
   );

   always_comb
   begin
      hFall    = prevHB && !vo.hBlank;
      vFall    = prevVB && !vo.vBlank;
      curX     = hFall ? 9'd0 : xReg + 9'd1;
      curLine  = vFall ? 8'd0 : (hFall ? lineReg + 8'd1 : lineReg);
      curValid = posValid || vFall;
      srcX     = curX[7:0] + refScroll;   // Wraps within the 256 pixel line
      pixAddr  = int'(curLine) * 128 + int'(srcX) / 2;
      pixByte  = bmRef[pixAddr];
      pixExp   = palRef[srcX[0] ? pixByte[7:4] : pixByte[3:0]];
      pixCond  = pixChk && curValid && !vo.hBlank && !vo.vBlank && bmKnown[pixAddr];
      // Request for line L+1 shows up while the output is at x 318 of line L
      reqSeen  = curValid && curX == 9'd318 && curLine[5:0] == 6'd63;
      ackSeen  = bus.wr && bus.addr == irqAckAddr;
      irqNow   = posValid ? refIrq : 1'b1;
      // Count inside the DUT runs two clocks ahead of the output
      aheadLine = (curX + 9'd2 >= 9'(hTotal)) ? curLine + 8'd1 : curLine;
      if (bus.addr <= bitmapLast)
         rdExpNow = bmRef[bus.addr[14:0]];
      else if (bus.addr == statusAddr)
         rdExpNow = {6'b0, irqNow, aheadLine >= 8'(vVisible)};
      else
         rdExpNow = 8'h00;
   end

   always @(posedge H2 or negedge arstN)
   begin
      if (!arstN)
      begin
         xReg     <= '0;
         lineReg  <= '0;
         posValid <= 1'b0;
         prevHB   <= 1'b0;
         prevVB   <= 1'b0;
         prevIrq  <= 1'b0;
         refIrq   <= 1'b0;
         rdKnown  <= 1'b0;
         rdPend   <= 1'b0;
      end
      else
      begin
         xReg     <= curX;
         lineReg  <= curLine;
         posValid <= curValid;
         prevHB   <= vo.hBlank;
         prevVB   <= vo.vBlank;
         prevIrq  <= irq;
         refIrq   <= reqSeen ? 1'b1 : (ackSeen ? 1'b0 : irqNow);   // Request wins
         rdPend   <= bus.rd && curValid;
         if (bus.rd && curValid)
         begin
            rdExp   <= rdExpNow;
            rdKnown <= 1'b1;
         end
         if (pixCond)
            pixChecks <= pixChecks + 1;
         if (vo.hBlank || vo.vBlank)
            blankChecks <= blankChecks + 1;
         if (rdPend)
            readChecks <= readChecks + 1;
         if (curValid && irq && !prevIrq)
            irqRises <= irqRises + 1;
      end
   end

   always @(posedge H2)
   begin
      if (bus.wr && bus.addr <= bitmapLast)
      begin
         bmRef[bus.addr[14:0]]   <= bus.wrData;
         bmKnown[bus.addr[14:0]] <= 1'b1;
      end
      if (bus.wr && bus.addr == scrollAddr)
         refScroll <= bus.wrData;
   end

   assert property (@(posedge H2) disable iff (!arstN) pixCond |-> vo.rgb == pixExp)
   else
   begin
      errCount++;
      $display("** Error: videoOut.rgb = 0x%0h, expected 0x%0h (x %0d, line %0d)",
               $sampled(vo.rgb), $sampled(pixExp), $sampled(curX), $sampled(curLine));
   end

   assert property (@(posedge H2) disable iff (!arstN) (vo.hBlank || vo.vBlank) |-> vo.rgb == '0)
   else
   begin
      errCount++;
      blankErrs++;
      $display("** Error: videoOut.rgb = 0x%0h in blanking, expected 0x0", $sampled(vo.rgb));
   end

   // Vertical blank covers lines 232 and up
   assert property (@(posedge H2) disable iff (!arstN)
                    curValid |-> vo.vBlank == (curLine >= 8'(vVisible)))
   else
   begin
      vbErrs++;
      $display("** Error: videoOut.vBlank = 0x%0h, expected 0x%0h (line %0d)",
               $sampled(vo.vBlank), $sampled(curLine >= 8'(vVisible)), $sampled(curLine));
   end

   assert property (@(posedge H2) disable iff (!arstN) curValid |-> irq == irqNow)
   else
   begin
      errCount++;
      $display("** Error: irq = 0x%0h, expected 0x%0h (x %0d, line %0d)",
               $sampled(irq), $sampled(irqNow), $sampled(curX), $sampled(curLine));
   end

   assert property (@(posedge H2) disable iff (!arstN) rdKnown |-> rdData == rdExp)
   else
   begin
      errCount++;
      $display("** Error: rdData = 0x%0h, expected 0x%0h", $sampled(rdData), $sampled(rdExp));
   end

   task automatic stepCycle();
      @(posedge H2);
      #1;
   endtask

   task automatic busCycle(input logic [15:0] addr, input logic [7:0] data, input logic wr);
      stepCycle();
      bus.addr   = addr;
      bus.wrData = data;
      bus.wr     = wr;
      bus.rd     = !wr;
      stepCycle();
      bus.wr = 1'b0;
      bus.rd = 1'b0;
   endtask

   task automatic waitFrameStart();
      do
         stepCycle();
      while (!vFall);
   endtask

   // Pixel checks cover exactly one visible frame
   task automatic checkFrame();
      waitFrameStart();
      pixChk = 1'b1;
      do
         stepCycle();
      while (!vo.vBlank);
      pixChk = 1'b0;
   endtask

   task automatic report(input string name, input int checks, input int errs);
      $display("test %-9s done: %0d checks, %0d errors", name, checks, errs);
   endtask

   initial
   begin : stimulus
      int          errStart;
      int          chkStart;
      int          line;
      int          x;
      logic [8:0]  palValue;
      logic [15:0] addrList [16];

      void'($urandom(32'h9660_bcdd));
      bus    = '0;
      pixChk = 1'b0;
      @(posedge arstN);
      waitFrameStart();

      // Interrupt and status
      errStart = errCount;
      chkStart = readChecks;
      for (int i = 0; i < 4; i++)
      begin
         while (!irq)
            stepCycle();
         busCycle(statusAddr, 8'h00, 1'b0);
         busCycle(irqAckAddr, 8'h00, 1'b1);
         busCycle(statusAddr, 8'h00, 1'b0);
      end
      while (!vo.vBlank)
         stepCycle();
      busCycle(statusAddr, 8'h00, 1'b0);
      if (irqRises < 3)
      begin
         errCount++;
         $display("irq did not rise at lines 64, 128 and 192");
      end
      report("irq", readChecks - chkStart + irqRises, errCount - errStart);

      // Bitmap readback, then palette and unmapped reads
      errStart = errCount;
      chkStart = readChecks;
      for (int i = 0; i < 16; i++)
      begin
         addrList[i] = 16'($urandom) & bitmapLast;
         busCycle(addrList[i], 8'($urandom), 1'b1);
      end
      for (int i = 0; i < 16; i++)
         busCycle(addrList[i], 8'h00, 1'b0);
      busCycle(paletteBase + 16'($urandom % paletteSize), 8'h00, 1'b0);
      busCycle(16'h9001, 8'h00, 1'b0);
      busCycle(16'hA000 + 16'($urandom % 24576), 8'h00, 1'b0);
      report("readback", readChecks - chkStart, errCount - errStart);

      // Palette, all entries nonzero
      errStart = errCount;
      chkStart = pixChecks;
      for (int i = 0; i < 16; i++)
      begin
         palValue = 9'($urandom);
         if (palValue == '0)
            palValue = 9'h1FF;
         busCycle(paletteBase + 16'(i) + (palValue[0] ? 16'd16 : 16'd0), palValue[8:1], 1'b1);
         palRef[i] = palValue;
      end
      for (int i = 0; i < 24; i++)
      begin
         line = int'($urandom % vVisible);
         x    = int'($urandom % hVisible);
         busCycle(16'(line * 128 + x / 2), 8'($urandom), 1'b1);
      end
      busCycle(scrollAddr, 8'h00, 1'b1);
      checkFrame();
      if (pixChecks == chkStart)
      begin
         errCount++;
         $display("no pixel was checked in the unscrolled frame");
      end
      report("pixel", pixChecks - chkStart, errCount - errStart);

      errStart = errCount;
      chkStart = pixChecks;
      busCycle(scrollAddr, 8'(1 + $urandom % 255), 1'b1);
      checkFrame();
      if (pixChecks == chkStart)
      begin
         errCount++;
         $display("no pixel was checked in the scrolled frame");
      end
      report("scroll", pixChecks - chkStart, errCount - errStart);

      if (hsChecks == 0 || vsChecks == 0 || hbChecks == 0)
      begin
         errCount++;
         $display("sync or blank timing was never measured");
      end
      report("timing", hsChecks + vsChecks + hbChecks, hsErrs + vsErrs + hbErrs + vbErrs);
      report("blanking", blankChecks, blankErrs);

      errCount = errCount + hsErrs + vsErrs + hbErrs + vbErrs;
      $display("tests 6, checks %0d, errors %0d",
               pixChecks + blankChecks + readChecks + hsChecks + vsChecks + hbChecks, errCount);
      if (errCount == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   initial
   begin : watchdog
      repeat (watchdogCycles) @(posedge H2);
      $display("Watchdog expired after %0d cycles", watchdogCycles);
      $display("TB FAILED");
      $finish;
   end

endmodule
